//--- hdl/video_defs.svh
// video raster front end constants for line length, frame height and bus widths
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// raster size in c3 counts and lines
`define VID_LINE_LEN 448
`define VID_FRAME_LINES 320

// DRAM word address width
`define VID_ADDR_W 21

// DRAM data word
`define VID_DATA_W 16

// the widest geometry ends exactly at the raster edges,
// so hpix_end may equal VID_LINE_LEN and vpix_end VID_FRAME_LINES
// (the window then runs to the last count of the line or frame)

`endif

//--- hdl/video_pkg.sv
// video package with the mode, render and resolution types and the config byte layout
package video_pkg;

	// vmod field of vconf
	typedef enum logic [2:0] {
		zx,         // ZX screen
		c16,        // 16 colours
		c256,       // 256 colours
		text,       // text mode
		rsv2,
		zx_hires,   // ZX hi-res test mode
		rsv1,
		nogfx       // no graphics fetch
	} vmode_e;

	// render mode as seen by the pixel renderer
	typedef enum logic [1:0] {
		r_zx,
		r_hc,
		r_xc,
		r_tx
	} render_e;

	// raster resolution, rres field of vconf
	typedef enum logic [1:0] {
		res256x192,
		res320x200,
		res320x240,
		res360x288
	} rres_e;

	typedef struct packed {
		rres_e       rres;    // bits 7:6
		logic [2:0]  spare;
		vmode_e      vmod;    // bits 2:0
	} vconf_t;

endpackage

//--- hdl/video_cfg_if.sv
// decoded video mode parameters shared by the mode decoder, sync and fetch blocks
`timescale 1ns/1ps

interface video_cfg_if;

	// active window geometry, in c3 counts and lines
	logic [8:0] hpix_beg;
	logic [8:0] hpix_end;
	logic [8:0] vpix_beg;
	logic [8:0] vpix_end;

	logic [5:0] x_tiles;    // fetch window length in 8-count tiles
	logic [4:0] go_offs;    // fetch lead ahead of hpix_beg

	video_pkg::render_e render_mode;
	logic               hires;    // pixel rate is f1 instead of c3

	modport src (
		output hpix_beg, hpix_end, vpix_beg, vpix_end,
		output x_tiles, go_offs,
		output render_mode, hires
	);

	modport dst (
		input hpix_beg, hpix_end, vpix_beg, vpix_end,
		input x_tiles, go_offs,
		input render_mode, hires
	);

endinterface

//--- hdl/video_sync.sv
// raster sync block with f1/c3 enable divider, h/v counters and active window flags
`timescale 1ns/1ps
`include "video_defs.svh"

module video_sync (
	input  logic       clk,
	input  logic       arst_n,
	video_cfg_if.dst   cfg,
	output logic       f1,
	output logic       c3,
	output logic [8:0] hcnt,
	output logic [8:0] vcnt,
	output logic       hwin,
	output logic       vwin
);

	localparam logic [8:0] H_LAST = 9'(`VID_LINE_LEN - 1);
	localparam logic [8:0] V_LAST = 9'(`VID_FRAME_LINES - 1);

	logic [1:0] phase;
	logic       h_end;
	logic       v_end;

	// clk phase, 0..3 from reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	assign f1 = phase[0];    // every second clk
	assign c3 = &phase;      // every fourth clk

	assign h_end = (hcnt == H_LAST);
	assign v_end = (vcnt == V_LAST);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (c3) begin
			if (h_end) begin
				hcnt <= '0;
				vcnt <= v_end ? 9'd0 : vcnt + 9'd1;    // new line
			end else begin
				hcnt <= hcnt + 9'd1;
			end
		end
	end

	// window flags, one clk behind the counters
	// counters only move on c3 so the flag is settled by the next c3
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hwin <= 1'b0;
			vwin <= 1'b0;
		end else begin
			hwin <= (hcnt >= cfg.hpix_beg) && (hcnt < cfg.hpix_end);
			vwin <= (vcnt >= cfg.vpix_beg) && (vcnt < cfg.vpix_end);
		end
	end

	// decoded geometry must fit inside the raster
	a_hwin_fit: assert property (@(posedge clk) disable iff (!arst_n)
		(cfg.hpix_beg < cfg.hpix_end) && (cfg.hpix_end <= 9'(`VID_LINE_LEN)))
		else $error("horizontal window outside the line");

	a_vwin_fit: assert property (@(posedge clk) disable iff (!arst_n)
		(cfg.vpix_beg < cfg.vpix_end) && (cfg.vpix_end <= 9'(`VID_FRAME_LINES)))
		else $error("vertical window outside the frame");

endmodule

//--- hdl/video_mode.sv
// video mode decoder with geometry tables, fetch strobes and DRAM address generation
`timescale 1ns/1ps
`include "video_defs.svh"

module video_mode (
	input  video_pkg::vconf_t       vconf,
	input  logic [7:0]              vpage,
	input  logic [8:0]              x_offs,
	input  logic [3:0]              fetch_cnt,
	input  logic [`VID_DATA_W-1:0]  txt_char,
	input  logic [7:0]              cnt_col,
	input  logic [8:0]              cnt_row,
	input  logic                    cptr,
	input  logic                    pix_start,
	input  logic                    f1,
	input  logic                    c3,
	video_cfg_if.src                cfg,
	output logic [9:0]              x_offs_mode,
	output logic [3:0]              fetch_sel,
	output logic [1:0]              fetch_bsl,
	output logic                    nogfx,
	output logic                    pix_stb,
	output logic                    fetch_stb,
	output logic [`VID_ADDR_W-1:0]  video_addr,
	output logic [3:0]              video_bw
);

	video_pkg::vmode_e       vmod;
	video_pkg::rres_e        rres;
	logic                    ftch;
	logic [11:0]             zx_gfx;
	logic [11:0]             zx_atr;
	logic [13:0]             tx_offs;
	logic [`VID_ADDR_W-1:0]  addr_zx;
	logic [`VID_ADDR_W-1:0]  addr_16c;
	logic [`VID_ADDR_W-1:0]  addr_256c;
	logic [`VID_ADDR_W-1:0]  addr_text;

	assign vmod = vconf.vmod;
	assign rres = vconf.rres;

	assign nogfx = (vmod == video_pkg::nogfx);
	assign pix_stb = cfg.hires ? f1 : c3;

	// per-mode lead, bandwidth, pixel rate and renderer
	always_comb begin
		cfg.go_offs = 5'd18;    // lead values found by trial
		video_bw = 4'b1001;     // 1 of 8
		cfg.hires = 1'b0;
		cfg.render_mode = video_pkg::r_zx;
		case (vmod)
			video_pkg::c16: begin
				cfg.go_offs = 5'd10;
				video_bw = 4'b1010;    // 2 of 8
				cfg.render_mode = video_pkg::r_hc;
			end
			video_pkg::c256: begin
				cfg.go_offs = 5'd6;
				video_bw = 4'b0010;    // 2 of 4
				cfg.render_mode = video_pkg::r_xc;
			end
			video_pkg::text: begin
				cfg.go_offs = 5'd10;
				video_bw = 4'b1100;    // 4 of 8
				cfg.hires = 1'b1;
				cfg.render_mode = video_pkg::r_tx;
			end
			video_pkg::zx_hires: begin
				cfg.go_offs = 5'd10;
				video_bw = 4'b1010;
				cfg.hires = 1'b1;
			end
			default: ;    // ZX and reserved
		endcase
	end

	// raster geometry per resolution
	always_comb begin
		case (rres)
			video_pkg::res256x192: begin
				cfg.hpix_beg = 9'd140;    // 88+52 border
				cfg.hpix_end = 9'd396;
				cfg.vpix_beg = 9'd80;
				cfg.vpix_end = 9'd272;
				cfg.x_tiles = 6'd33;
			end
			video_pkg::res320x200: begin
				cfg.hpix_beg = 9'd108;
				cfg.hpix_end = 9'd428;
				cfg.vpix_beg = 9'd76;
				cfg.vpix_end = 9'd276;
				cfg.x_tiles = 6'd41;
			end
			video_pkg::res320x240: begin
				cfg.hpix_beg = 9'd108;
				cfg.hpix_end = 9'd428;
				cfg.vpix_beg = 9'd56;
				cfg.vpix_end = 9'd296;
				cfg.x_tiles = 6'd41;
			end
			default: begin    // 360x288, no border
				cfg.hpix_beg = 9'd88;
				cfg.hpix_end = 9'd448;
				cfg.vpix_beg = 9'd32;
				cfg.vpix_end = 9'd320;
				cfg.x_tiles = 6'd46;
			end
		endcase
	end

	// word fetch rate follows the renderer
	always_comb begin
		case (cfg.render_mode)
			video_pkg::r_hc: ftch = &fetch_cnt[2:0];
			video_pkg::r_xc: ftch = &fetch_cnt[1:0];
			default:         ftch = &fetch_cnt;    // zx and text, 1 per 16
		endcase
	end

	assign fetch_stb = (pix_start | ftch) & c3;

	// cnt_col is already the incremented column when the word is fetched
	always_comb begin
		fetch_sel = {~cptr, ~cptr, cptr, cptr};
		fetch_bsl = 2'b10;
		tx_offs = {1'b0, cnt_row[8:3], 1'b0, cnt_col[7:2]};    // char codes
		if (vmod == video_pkg::text) begin
			case (cnt_col[1:0])
				2'd1: fetch_sel = 4'b0011;    // char
				2'd2: begin
					fetch_sel = 4'b1100;    // attr
					tx_offs = {1'b0, cnt_row[8:3], 1'b1, cnt_col[7:2]};
				end
				2'd3: begin
					fetch_sel = 4'b0001;    // gfx0
					fetch_bsl = {2{cnt_row[0]}};
					tx_offs = {4'b1000, txt_char[7:0], cnt_row[2:1]};
				end
				default: begin
					fetch_sel = 4'b0010;    // gfx1
					fetch_bsl = {2{cnt_row[0]}};
					tx_offs = {4'b1000, txt_char[15:8], cnt_row[2:1]};
				end
			endcase
		end
	end

	// 256c scrolls in whole pixels, the rest in pairs
	assign x_offs_mode = (vmod == video_pkg::c256) ? {x_offs[8:1], 1'b0, x_offs[0]}
		: {1'b0, x_offs[8:1], x_offs[0]};

	// ZX layout with thirds, attributes at word 0xc00
	assign zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};
	assign addr_zx = {vpage, 1'b0, cnt_col[0] ? zx_atr : zx_gfx};

	assign addr_16c = {vpage[7:3], cnt_row, cnt_col[6:0]};
	assign addr_256c = {vpage[7:4], cnt_row, cnt_col};
	assign addr_text = {vpage[7:1], tx_offs};

	always_comb begin
		case (vmod)
			video_pkg::c16:  video_addr = addr_16c;
			video_pkg::c256: video_addr = addr_256c;
			video_pkg::text: video_addr = addr_text;
			default:         video_addr = addr_zx;
		endcase
	end

endmodule

//--- hdl/video_fetch.sv
// fetch sequencer with line fetch window, column/row counters and text char latch
`timescale 1ns/1ps
`include "video_defs.svh"

module video_fetch (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    f1,
	input  logic                    c3,
	input  logic [8:0]              hcnt,
	input  logic [8:0]              vcnt,
	input  logic                    vwin,
	input  logic                    fetch_stb,
	input  logic [`VID_DATA_W-1:0]  dram_rdata,
	video_cfg_if.dst                cfg,
	output logic [3:0]              fetch_cnt,
	output logic [7:0]              cnt_col,
	output logic [8:0]              cnt_row,
	output logic                    cptr,
	output logic                    pix_start,
	output logic [`VID_DATA_W-1:0]  txt_char
);

	logic [8:0] go_pos;
	logic [8:0] win_len;
	logic [8:0] win_cnt;
	logic       fetch_on;
	logic       win_last;
	logic [7:0] col_q;

	// fetch starts go_offs counts ahead of the first pixel
	assign go_pos = cfg.hpix_beg - 9'(cfg.go_offs);
	assign pix_start = c3 && vwin && (hcnt == go_pos);

	assign win_len = {cfg.x_tiles, 3'b000};    // 8 counts per tile
	assign win_last = fetch_on && (win_cnt == win_len - 9'd1);

	// fetch_cnt parks at zero outside the window so no pattern strobe fires
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fetch_on <= 1'b0;
			win_cnt <= '0;
			fetch_cnt <= '0;
		end else if (c3) begin
			if (pix_start) begin
				fetch_on <= 1'b1;
				win_cnt <= '0;
				fetch_cnt <= '0;
			end else if (win_last) begin
				fetch_on <= 1'b0;
				win_cnt <= '0;
				fetch_cnt <= '0;
			end else if (fetch_on) begin
				win_cnt <= win_cnt + 9'd1;
				fetch_cnt <= fetch_cnt + 4'd1;
			end
		end
	end

	// column seen by the decoder is already advanced on the strobe
	assign cnt_col = (pix_start ? 8'd0 : col_q) + {7'd0, fetch_stb};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col_q <= '0;
			cptr <= 1'b0;
		end else if (fetch_stb) begin
			col_q <= cnt_col;
			cptr <= ~cptr;    // ZX gfx/attr word select
		end
	end

	assign cnt_row = vcnt - cfg.vpix_beg;

	// char word comes back at column 1, gfx fetches use it after
	always_ff @(posedge clk) begin
		if (fetch_stb && (cnt_col[1:0] == 2'd1) && (cfg.render_mode == video_pkg::r_tx))
			txt_char <= dram_rdata;
	end

	a_col_range: assert property (@(posedge clk) disable iff (!arst_n)
		cnt_col <= {cfg.x_tiles, 2'b00})
		else $error("cnt_col ran past the fetch window");

	// strobes from the decoder must land on a sync f1 phase
	a_stb_phase: assert property (@(posedge clk) disable iff (!arst_n) fetch_stb |-> f1)
		else $error("fetch_stb off the f1 phase");

endmodule

//--- hdl/video_top.sv
// video front end top joining sync, mode decoder and fetch sequencer
`timescale 1ns/1ps
`include "video_defs.svh"

module video_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [7:0]              vconf,
	input  logic [7:0]              vpage,
	input  logic [8:0]              x_offs,
	input  logic [`VID_DATA_W-1:0]  dram_rdata,
	output logic [`VID_ADDR_W-1:0]  video_addr,
	output logic [3:0]              video_bw,
	output logic                    fetch_stb,
	output logic [3:0]              fetch_sel,
	output logic [1:0]              fetch_bsl,
	output logic [9:0]              x_offs_mode,
	output logic [1:0]              render_mode,
	output logic                    hires,
	output logic                    nogfx,
	output logic                    pix_stb,
	output logic                    disp_en
);

	video_pkg::vconf_t       vconf_s;
	logic                    f1;
	logic                    c3;
	logic [8:0]              hcnt;
	logic [8:0]              vcnt;
	logic                    hwin;
	logic                    vwin;
	logic [3:0]              fetch_cnt;
	logic [7:0]              cnt_col;
	logic [8:0]              cnt_row;
	logic                    cptr;
	logic                    pix_start;
	logic [`VID_DATA_W-1:0]  txt_char;

	video_cfg_if cfg_if ();

	assign vconf_s = video_pkg::vconf_t'(vconf);

	video_sync sync_i (
		.clk    (clk),
		.arst_n (arst_n),
		.cfg    (cfg_if.dst),
		.f1     (f1),
		.c3     (c3),
		.hcnt   (hcnt),
		.vcnt   (vcnt),
		.hwin   (hwin),
		.vwin   (vwin)
	);

	video_mode mode_i (
		.vconf       (vconf_s),
		.vpage       (vpage),
		.x_offs      (x_offs),
		.fetch_cnt   (fetch_cnt),
		.txt_char    (txt_char),
		.cnt_col     (cnt_col),
		.cnt_row     (cnt_row),
		.cptr        (cptr),
		.pix_start   (pix_start),
		.f1          (f1),
		.c3          (c3),
		.cfg         (cfg_if.src),
		.x_offs_mode (x_offs_mode),
		.fetch_sel   (fetch_sel),
		.fetch_bsl   (fetch_bsl),
		.nogfx       (nogfx),
		.pix_stb     (pix_stb),
		.fetch_stb   (fetch_stb),
		.video_addr  (video_addr),
		.video_bw    (video_bw)
	);

	video_fetch fetch_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.f1         (f1),
		.c3         (c3),
		.hcnt       (hcnt),
		.vcnt       (vcnt),
		.vwin       (vwin),
		.fetch_stb  (fetch_stb),
		.dram_rdata (dram_rdata),
		.cfg        (cfg_if.dst),
		.fetch_cnt  (fetch_cnt),
		.cnt_col    (cnt_col),
		.cnt_row    (cnt_row),
		.cptr       (cptr),
		.pix_start  (pix_start),
		.txt_char   (txt_char)
	);

	assign render_mode = cfg_if.render_mode;
	assign hires = cfg_if.hires;
	assign disp_en = hwin & vwin;    // both flags registered in sync_i

endmodule

//--- verification/video_tb.sv
// video front end testbench with directed tests for reset, mode table, raster window, fetch and scroll
`timescale 1ns/1ps
`include "video_defs.svh"

module video_tb;

	localparam int LINE_CLK = `VID_LINE_LEN * 4;
	localparam int FRAME_CLK = LINE_CLK * `VID_FRAME_LINES;

	// per vmod: render mode, hires, nogfx, bandwidth code
	localparam int MODE_TAB [8][4] = '{
		'{0, 0, 0, 9}, '{1, 0, 0, 10}, '{2, 0, 0, 2}, '{3, 1, 0, 12},
		'{0, 0, 0, 9}, '{0, 1, 0, 10}, '{0, 0, 0, 9}, '{0, 0, 1, 9}
	};

	// per rres: hpix_beg, hpix_end, vpix_beg, vpix_end, x_tiles
	localparam int GEOM [4][5] = '{
		'{140, 396, 80, 272, 33}, '{108, 428, 76, 276, 41},
		'{108, 428, 56, 296, 41}, '{88, 448, 32, 320, 46}
	};

	logic        clk;
	logic        arst_n;
	logic [7:0]  vconf;
	logic [7:0]  vpage;
	logic [8:0]  x_offs;
	logic [15:0] dram_rdata;
	logic [20:0] video_addr;
	logic [3:0]  video_bw;
	logic        fetch_stb;
	logic [3:0]  fetch_sel;
	logic [1:0]  fetch_bsl;
	logic [9:0]  x_offs_mode;
	logic [1:0]  render_mode;
	logic        hires;
	logic        nogfx;
	logic        pix_stb;
	logic        disp_en;

	logic [1:0]  phase;    // clk phase, c3 at 3
	int          hpos;
	int          vpos;

	logic [31:0] rng;
	string       test_name;
	int          test_errs;
	int          err_total;
	int          tests_run;
	int          tests_failed;
	bit          timed_out;

	video_top dut_i (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// own raster position, counts move at the end of each c3 clk
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= 2'd0;
			hpos <= 0;
			vpos <= 0;
		end else begin
			phase <= phase + 2'd1;
			if (phase == 2'd3) begin
				if (hpos == `VID_LINE_LEN - 1) begin
					hpos <= 0;
					vpos <= (vpos == `VID_FRAME_LINES - 1) ? 0 : vpos + 1;
				end else begin
					hpos <= hpos + 1;
				end
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// c3 counts between pattern fetches
	function automatic int fetch_period(input int m);
		if (m == 1)
			return 8;
		if (m == 2)
			return 4;
		return 16;
	endfunction

	function automatic int expect_addr(input int m, input int page, input int row,
		input int col, input int chr);
		int tx;
		int blk;
		blk = ((row >> 3) & 63) << 7;    // text row of 8 lines
		case (m)
			1: return ((page >> 3) << 16) | (row << 7) | (col & 127);
			2: return ((page >> 4) << 17) | (row << 8) | (col & 255);
			3: begin
				case (col % 4)
					1: tx = blk | ((col >> 2) & 63);          // char
					2: tx = blk | 64 | ((col >> 2) & 63);     // attr
					3: tx = 8192 | ((chr & 255) << 2) | ((row >> 1) & 3);
					default: tx = 8192 | (((chr >> 8) & 255) << 2) | ((row >> 1) & 3);
				endcase
				return ((page >> 1) << 14) | tx;
			end
			default: begin
				if (col % 2 == 1)
					tx = 3072 | (((row >> 3) & 31) << 4) | ((col >> 1) & 15);
				else
					tx = (((row >> 6) & 3) << 10) | ((row & 7) << 7)
						| (((row >> 3) & 7) << 4) | ((col >> 1) & 15);
				return (page << 13) | tx;
			end
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act == exp) else begin
			$display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%s: %s", test_name, what);
			test_errs++;
		end
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic close_test();
		tests_run++;
		err_total += test_errs;
		if (test_errs == 0) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", test_name, test_errs);
		end
	endtask

	task automatic set_mode(input int vmod, input int rres);
		video_pkg::vconf_t cw;
		cw.rres = video_pkg::rres_e'(rres[1:0]);
		cw.spare = 3'b000;
		cw.vmod = video_pkg::vmode_e'(vmod[2:0]);
		vconf = cw;
	endtask

	// stops on phase 0 at the given raster count and line
	task automatic wait_raster(input int h, input int v);
		int n;
		n = 0;
		while (!(phase == 2'd0 && hpos == h && vpos == v) && n < 2 * FRAME_CLK) begin
			@(negedge clk);
			n++;
		end
		if (!(phase == 2'd0 && hpos == h && vpos == v)) begin
			$display("Timeout: raster never reached line %0d count %0d", v, h);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_fetch_stb(input int limit);
		int n;
		n = 0;
		while (!fetch_stb && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!fetch_stb) begin
			$display("Timeout: no fetch_stb within %0d clk", limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic test_reset();
		int n;
		open_test("reset");
		for (n = 0; n < 16; n++) begin
			@(negedge clk);
			check_true(!fetch_stb && !disp_en, "fetch_stb or disp_en high in reset");
		end
		arst_n = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			check_true(!fetch_stb && !disp_en, "fetch_stb or disp_en high before first c3");
			n++;
		end while (phase != 2'd3 && n < 8);
		check_true(phase == 2'd3, "no c3 phase within 8 clk of reset release");
		close_test();
	endtask

	task automatic test_mode_table();
		int m;
		int k;
		int cnt;
		bit exp_stb;
		open_test("mode_table");
		for (m = 0; m < 8; m++) begin
			set_mode(m, 0);
			@(negedge clk);
			check_value($sformatf("render vmod %0d", m), MODE_TAB[m][0], 32'(render_mode));
			check_value($sformatf("hires vmod %0d", m), MODE_TAB[m][1], 32'(hires));
			check_value($sformatf("nogfx vmod %0d", m), MODE_TAB[m][2], 32'(nogfx));
			check_value($sformatf("bw vmod %0d", m), MODE_TAB[m][3], 32'(video_bw));
			cnt = 0;
			for (k = 0; k < 8; k++) begin
				exp_stb = (MODE_TAB[m][1] != 0) ? phase[0] : (phase == 2'd3);
				check_value($sformatf("pix_stb vmod %0d phase %0d", m, phase),
					32'(exp_stb), 32'(pix_stb));
				cnt += int'(pix_stb);
				@(negedge clk);
			end
			check_value($sformatf("pix_stb per 8 clk vmod %0d", m),
				(MODE_TAB[m][1] != 0) ? 4 : 2, cnt);
		end
		close_test();
	endtask

	task automatic test_scroll();
		int unsigned x;
		int exp;
		int m;
		int i;
		open_test("scroll");
		for (m = 0; m < 3; m++) begin    // zx, c16, c256
			for (i = 0; i < 8; i++) begin
				rng = xorshift32(rng);
				x = 32'(rng[8:0]);
				set_mode(m, 0);
				x_offs = rng[8:0];
				@(negedge clk);
				exp = (m == 2) ? (((x >> 1) << 2) | (x & 1)) : x;    // 256c keeps odd pixel
				check_value($sformatf("x_offs %0h vmod %0d", x, m), exp, 32'(x_offs_mode));
			end
		end
		close_test();
	endtask

	task automatic test_raster();
		int r;
		int n;
		int cnt;
		int lines;
		open_test("raster");
		for (r = 0; r < 4 && !timed_out; r++) begin
			wait_raster(0, 0);
			set_mode(0, r);
			lines = 0;
			cnt = 0;
			for (n = 0; n < FRAME_CLK && !timed_out; n++) begin
				if (phase == 2'd3 && pix_stb && disp_en)
					cnt++;
				if (phase == 2'd3 && hpos == `VID_LINE_LEN - 1) begin    // last count of line
					if (cnt != 0) begin
						lines++;
						check_value($sformatf("width rres %0d line %0d", r, vpos),
							GEOM[r][1] - GEOM[r][0], cnt);
					end
					cnt = 0;
				end
				@(negedge clk);
			end
			check_value($sformatf("lines rres %0d", r), GEOM[r][3] - GEOM[r][2], lines);
		end
		close_test();
	endtask

	task automatic test_fetch(input int m, input int r, input string name);
		int sel_tab [4] = '{2, 3, 12, 1};    // gfx1, char, attr, gfx0
		int page;
		int col;
		int row;
		int chr;
		int n;
		int exp_bsl;
		open_test(name);
		wait_raster(0, 0);
		rng = xorshift32(rng);
		page = 32'(rng[7:0]);
		vpage = rng[7:0];
		set_mode(m, r);
		if (!timed_out)
			wait_raster(0, GEOM[r][2]);
		if (!timed_out)
			wait_fetch_stb(LINE_CLK);
		col = 0;
		chr = 0;
		row = vpos - GEOM[r][2];
		for (n = 0; n < LINE_CLK && !timed_out && vpos == GEOM[r][2]; n++) begin
			if (fetch_stb) begin
				col++;    // first strobe is column 1
				check_true(phase == 2'd3, "fetch_stb outside the c3 phase");
				if (m == 3 && col % 4 == 1) begin
					rng = xorshift32(rng);
					dram_rdata = rng[15:0];    // char word returned now
					chr = 32'(rng[15:0]);
				end
				check_value($sformatf("addr col %0d", col),
					expect_addr(m, page, row, col, chr), 32'(video_addr));
				if (m == 3) begin
					exp_bsl = (col % 4 == 1 || col % 4 == 2) ? 2 : (((row & 1) != 0) ? 3 : 0);
					check_value($sformatf("sel col %0d", col), sel_tab[col % 4], 32'(fetch_sel));
					check_value($sformatf("bsl col %0d", col), exp_bsl, 32'(fetch_bsl));
				end
			end
			@(negedge clk);
		end
		if (!timed_out)
			check_value("strobes per line", 1 + GEOM[r][4] * 8 / fetch_period(m), col);
		close_test();
	endtask

	initial begin
		rng = 32'h29882e9f;
		arst_n = 1'b0;
		vconf = 8'd0;
		vpage = 8'd0;
		x_offs = 9'd0;
		dram_rdata = 16'd0;
		err_total = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;

		test_reset();
		test_mode_table();
		test_scroll();
		test_raster();
		if (!timed_out)
			test_fetch(0, 0, "fetch_zx");
		if (!timed_out)
			test_fetch(1, 1, "fetch_16c");
		if (!timed_out)
			test_fetch(2, 2, "fetch_256c");
		if (!timed_out)
			test_fetch(3, 3, "fetch_text");

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, err_total);
		if (err_total == 0 && !timed_out)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- sources.f
+incdir+hdl
hdl/video_pkg.sv
hdl/video_cfg_if.sv
hdl/video_sync.sv
hdl/video_mode.sv
hdl/video_fetch.sv
hdl/video_top.sv
verification/video_tb.sv

//--- run.sh
#!/bin/sh
# build the video front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module video_tb -o video_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/video_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
